/* Makefile */
# Verilator build for the MSU-1 streaming path testbench

VERILATOR ?= verilator
TOP       ?= msu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed

SOURCES := $(wildcard hw/*.sv hw/*.svh dv/*.sv dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Result comes from the log, a crash leaves no pass line
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/msu_tb_host.svh */
// ============================================================
// Host sector server model and timed waits for the MSU testbench
// Serves one channel at a time, data before audio
// Word i of block b is {b[7:0], i[7:0]}
// ============================================================
`ifndef MSU_TB_HOST_SVH
`define MSU_TB_HOST_SVH

// Inputs change 1 ns after the rising edge
task automatic drive_edge();
	@(posedge clk_sys);
	#1;
endtask

// Reference word of the host image
function automatic sd_word_t pattern_word(input sd_lba_t lba, input int idx);
	return {lba[7:0], 8'(idx)};
endfunction

// One sector: ack, a full burst of word strobes, then ack low
task automatic serve_sector(input bit audio, input sd_lba_t lba);
	if (audio) begin
		served_audio.push_back(lba);
		drive_edge();
		sd_ack_audio = 1'b1;
	end else begin
		served_data.push_back(lba);
		drive_edge();
		sd_ack_data = 1'b1;
	end
	for (int i = 0; i < `MSU_SECTOR_WORDS; i++) begin
		drive_edge();
		sd_buff_wr   = 1'b1;
		sd_buff_dout = pattern_word(lba, i);
	end
	drive_edge();
	sd_buff_wr   = 1'b0;
	sd_ack_audio = 1'b0;
	sd_ack_data  = 1'b0;
endtask

// Requests are sampled on the falling edge where they are stable
task automatic run_host();
	forever begin
		@(negedge clk_sys);
		if (!reset && sd_rd_data) begin
			serve_sector(1'b0, sd_lba_data);
		end else if (!reset && sd_rd_audio) begin
			serve_sector(1'b1, sd_lba_audio);
		end
	end
endtask

// ============================================================
// Waits, each bounded by its own cycle limit
// ============================================================

task automatic wait_busy(input logic level, input int limit, output bit got);
	got = 1'b0;
	for (int i = 0; i < limit && !got; i++) begin
		@(negedge clk_sys);
		got = (msu_data_busy == level);
	end
endtask

task automatic wait_audio_served(input int count, input int limit, output bit got);
	got = 1'b0;
	for (int i = 0; i < limit && !got; i++) begin
		@(negedge clk_sys);
		got = (served_audio.size() >= count);
	end
endtask

task automatic wait_audio_rise(input int limit, output bit got);
	got = 1'b0;
	for (int i = 0; i < limit && !got; i++) begin
		@(negedge clk_sys);
		got = (audio_rises > 0);
	end
endtask

// Output leaves the plain halved main value once an MSU pair lands
task automatic wait_pair(input pcm_sample_t ml, input pcm_sample_t mr, input int limit,
	output bit got);
	got = 1'b0;
	for (int i = 0; i < limit && !got; i++) begin
		@(negedge clk_sys);
		got = (audio_l != half_sum(ml, '0)) || (audio_r != half_sum(mr, '0));
	end
endtask

`endif

/* dv/msu_tb.sv */
// ============================================================
// Testbench for the MSU-1 streaming path
// Mixer runs at the real pacer rate, so audio waits are long
// Test table is built once from a fixed LCG seed
// ============================================================
`timescale 1ns/1ps
`include "msu_params.svh"

module msu_tb
	import msu_sd_pkg::*, msu_audio_pkg::*;
();

	localparam int N_TESTS   = 7;
	localparam int BYTE_BITS = $clog2(`MSU_SECTOR_WORDS * 2);

	typedef enum int {
		k_idle, k_data_miss, k_data_hit, k_audio_start, k_stream, k_restart, k_mount
	} test_kind_t;

	typedef struct {
		string       name;
		test_kind_t  kind;
		logic [31:0] addr;
		logic        trig;
		pcm_sample_t main_l;
		pcm_sample_t main_r;
		logic [31:0] exp_blk;
		logic [31:0] exp_a;
		logic [31:0] exp_b;
	} test_entry_t;

	logic        clk_sys;
	logic        reset;
	logic        sd_rd_audio;
	sd_lba_t     sd_lba_audio;
	logic        sd_rd_data;
	sd_lba_t     sd_lba_data;
	logic        sd_ack_audio;
	logic        sd_ack_data;
	sd_word_t    sd_buff_dout;
	logic        sd_buff_wr;
	logic        msu_trig_play;
	logic        msu_trackmounting;
	logic [31:0] msu_data_addr;
	logic [7:0]  msu_data_in;
	logic        msu_data_busy;
	logic        msu_audio_playing;
	pcm_sample_t main_audio_l;
	pcm_sample_t main_audio_r;
	pcm_sample_t audio_l;
	pcm_sample_t audio_r;

	// Host model record and request monitor
	sd_lba_t     served_audio[$];
	sd_lba_t     served_data[$];
	int          audio_rises;
	int          data_rises;
	int          ack_overlaps;
	logic        rd_audio_q;
	logic        rd_data_q;
	logic [31:0] lcg_state;
	test_entry_t tests [N_TESTS];
	int          passed;

	// Signed sum halved, fraction rounded toward minus infinity
	function automatic pcm_sample_t half_sum(input pcm_sample_t a, input pcm_sample_t b);
		int s;
		s = int'(a) + int'(b);
		return pcm_sample_t'(s >>> 1);
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Byte the data buffer should return for a byte address
	function automatic logic [7:0] expected_byte(input logic [31:0] addr);
		sd_word_t w;
		w = pattern_word(addr >> BYTE_BITS, int'(addr[BYTE_BITS-1:1]));
		return addr[0] ? w[15:8] : w[7:0];
	endfunction

	`include "msu_tb_host.svh"

	msu_top dut_i (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.sd_rd_audio       (sd_rd_audio),
		.sd_lba_audio      (sd_lba_audio),
		.sd_rd_data        (sd_rd_data),
		.sd_lba_data       (sd_lba_data),
		.sd_ack_audio      (sd_ack_audio),
		.sd_ack_data       (sd_ack_data),
		.sd_buff_dout      (sd_buff_dout),
		.sd_buff_wr        (sd_buff_wr),
		.msu_trig_play     (msu_trig_play),
		.msu_trackmounting (msu_trackmounting),
		.msu_data_addr     (msu_data_addr),
		.msu_data_in       (msu_data_in),
		.msu_data_busy     (msu_data_busy),
		.msu_audio_playing (msu_audio_playing),
		.main_audio_l      (main_audio_l),
		.main_audio_r      (main_audio_r),
		.audio_l           (audio_l),
		.audio_r           (audio_r)
	);

	// 4 ns clock
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial run_host();

	// Request rises, and audio rises while the host still holds the ack
	always @(negedge clk_sys) begin
		if (reset) begin
			rd_audio_q = 1'b0;
			rd_data_q  = 1'b0;
		end else begin
			if (sd_rd_audio && !rd_audio_q) begin
				audio_rises++;
				if (sd_ack_audio) begin
					ack_overlaps++;
				end
			end
			if (sd_rd_data && !rd_data_q) begin
				data_rises++;
			end
			rd_audio_q = sd_rd_audio;
			rd_data_q  = sd_rd_data;
		end
	end

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got, inout bit ok);
		assert (got === exp) else begin
			$display("** Error %s: expected %0h, actual %0h", name, exp, got);
			ok = 1'b0;
		end
	endtask

	task automatic check_true(input string name, input bit cond, input string what,
		inout bit ok);
		assert (cond) else begin
			$display("%s: %s", name, what);
			ok = 1'b0;
		end
	endtask

	// One-cycle trigger, then forget what was served before it
	task automatic trigger_play();
		drive_edge();
		msu_trig_play = 1'b1;
		drive_edge();
		msu_trig_play = 1'b0;
		served_audio.delete();
		audio_rises = 0;
	endtask

	task automatic set_row(input int i, input string name, input test_kind_t kind,
		input logic [31:0] addr, input logic trig);
		logic [31:0] r;
		r = lcg_next();
		tests[i].name    = name;
		tests[i].kind    = kind;
		tests[i].addr    = addr;
		tests[i].trig    = trig;
		tests[i].main_l  = r[31:16];
		tests[i].main_r  = r[15:0];
		tests[i].exp_blk = '0;
		tests[i].exp_a   = '0;
		tests[i].exp_b   = '0;
	endtask

	task automatic build_table();
		logic [31:0] addr_a;
		logic [31:0] addr_b;
		logic [31:0] r;
		lcg_state = 32'h6c266035;
		// Bit 9 set so the first address misses the sector fetched after reset
		r      = lcg_next();
		addr_a = r | 32'h200;
		r      = lcg_next();
		addr_b = {addr_a[31:BYTE_BITS], r[BYTE_BITS-1:0]};
		set_row(0, "reset_idle", k_idle, '0, 1'b0);
		set_row(1, "data_fetch", k_data_miss, addr_a, 1'b0);
		set_row(2, "data_same_sector", k_data_hit, addr_b, 1'b0);
		set_row(3, "audio_start", k_audio_start, '0, 1'b1);
		set_row(4, "streaming", k_stream, '0, 1'b0);
		set_row(5, "restart", k_restart, '0, 1'b1);
		set_row(6, "track_mounting", k_mount, '0, 1'b1);
		tests[0].exp_a = {16'h0, half_sum(tests[0].main_l, '0)};
		tests[0].exp_b = {16'h0, half_sum(tests[0].main_r, '0)};
		// Host block is the byte address divided by the sector size
		tests[1].exp_blk = addr_a >> BYTE_BITS;
		tests[1].exp_a   = {24'h0, expected_byte(addr_a)};
		tests[2].exp_a   = {24'h0, expected_byte(addr_b)};
		// First pair follows the header words of block 0
		tests[3].exp_a = {16'h0, half_sum(tests[3].main_l,
			pattern_word('0, `MSU_HEADER_WORDS))};
		tests[3].exp_b = {16'h0, half_sum(tests[3].main_r,
			pattern_word('0, `MSU_HEADER_WORDS + 1))};
	endtask

	task automatic run_test(input test_entry_t t);
		bit ok;
		bit got;
		ok = 1'b1;
		drive_edge();
		main_audio_l      = t.main_l;
		main_audio_r      = t.main_r;
		msu_trackmounting = (t.kind == k_mount);
		if (t.trig) begin
			trigger_play();
		end
		case (t.kind)
			k_idle: begin
				@(negedge clk_sys);
				check_value(t.name, t.exp_a, {16'h0, audio_l}, ok);
				check_value(t.name, t.exp_b, {16'h0, audio_r}, ok);
				check_value(t.name, 32'h0, {31'h0, msu_audio_playing}, ok);
			end
			k_data_miss: begin
				// Fetch started by the reset address ends first
				wait_busy(1'b0, 2000, got);
				check_true(t.name, got, "data busy stayed high after reset", ok);
				drive_edge();
				served_data.delete();
				msu_data_addr = t.addr;
				wait_busy(1'b1, 20, got);
				check_true(t.name, got, "data busy never rose for a new sector", ok);
				wait_busy(1'b0, 2000, got);
				check_true(t.name, got, "data busy never fell after the fetch", ok);
				check_true(t.name, served_data.size() == 1,
					"data sector was not served exactly once", ok);
				if (served_data.size() > 0) begin
					check_value(t.name, t.exp_blk, served_data[0], ok);
				end
				check_value(t.name, t.exp_a, {24'h0, msu_data_in}, ok);
			end
			k_data_hit: begin
				drive_edge();
				data_rises    = 0;
				msu_data_addr = t.addr;
				repeat (50) @(negedge clk_sys);
				check_value(t.name, t.exp_b, data_rises, ok);
				check_value(t.name, t.exp_a, {24'h0, msu_data_in}, ok);
			end
			k_audio_start, k_restart: begin
				wait_audio_served(1, 2000, got);
				check_true(t.name, got, "no audio sector was served after the trigger", ok);
				if (got) begin
					check_value(t.name, t.exp_blk, served_audio[0], ok);
				end
				if (t.kind == k_audio_start) begin
					wait_pair(t.main_l, t.main_r, 8000, got);
					check_true(t.name, got, "MSU samples never reached the output", ok);
					check_value(t.name, t.exp_a, {16'h0, audio_l}, ok);
					check_value(t.name, t.exp_b, {16'h0, audio_r}, ok);
				end
			end
			k_stream: begin
				wait_audio_served(3, 4000, got);
				check_true(t.name, got, "fewer than three audio sectors were served", ok);
				for (int k = 0; k < 3 && got; k++) begin
					check_value(t.name, t.exp_blk + k, served_audio[k], ok);
				end
				check_value(t.name, t.exp_b, ack_overlaps, ok);
			end
			k_mount: begin
				repeat (100) @(negedge clk_sys);
				check_value(t.name, t.exp_a, audio_rises, ok);
				drive_edge();
				msu_trackmounting = 1'b0;
				wait_audio_rise(1000, got);
				check_true(t.name, got, "no audio request after mounting ended", ok);
			end
			default: check_true(t.name, 1'b0, "unknown test kind in the table", ok);
		endcase
		if (ok) begin
			$display("PASS  %s", t.name);
			passed++;
		end else begin
			$display("FAIL  %s", t.name);
		end
	endtask

	initial begin
		reset             = 1'b1;
		msu_trig_play     = 1'b0;
		msu_trackmounting = 1'b0;
		msu_data_addr     = '0;
		sd_ack_audio      = 1'b0;
		sd_ack_data       = 1'b0;
		sd_buff_dout      = '0;
		sd_buff_wr        = 1'b0;
		main_audio_l      = '0;
		main_audio_r      = '0;
		audio_rises       = 0;
		data_rises        = 0;
		ack_overlaps      = 0;
		passed            = 0;
		build_table();
		repeat (3) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		for (int t = 0; t < N_TESTS; t++) begin
			run_test(tests[t]);
		end
		$display("Tests run: %0d, passed: %0d, failed: %0d", N_TESTS, passed, N_TESTS - passed);
		if (passed == N_TESTS) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+hw
+incdir+dv
hw/msu_sd_pkg.sv
hw/msu_audio_pkg.sv
hw/msu_sector_ctrl.sv
hw/msu_sample_fifo.sv
hw/msu_audio_mixer.sv
hw/msu_data_buffer.sv
hw/msu_top.sv
dv/msu_tb.sv

/* hw/msu_audio_mixer.sv */
// ============================================================
// MSU sample pacer and mix with the console audio
// One FIFO word per tick, left then right
// Sum is halved, so no clipping but 6 dB less on each source
// ============================================================
`timescale 1ns/1ps
`include "msu_params.svh"

module msu_audio_mixer
	import msu_audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        msu_audio_playing,
	input  logic        fifo_empty,
	input  logic        first_sample_sync,
	input  pcm_sample_t fifo_dout,
	input  pcm_sample_t main_audio_l,
	input  pcm_sample_t main_audio_r,
	output logic        fifo_rd,
	output pcm_sample_t audio_l,
	output pcm_sample_t audio_r
);

	localparam int DIV_W = $clog2(`MSU_SAMPLE_DIV + 1);

	logic [DIV_W-1:0]   div_cnt;
	logic               tick;
	logic               rd_valid;
	logic               is_left;
	pcm_sample_t        held_left;
	pcm_sample_t        pair_l;
	pcm_sample_t        pair_r;
	pcm_sample_t        msu_l;
	pcm_sample_t        msu_r;
	logic signed [16:0] mix_l;
	logic signed [16:0] mix_r;

	// ============================================================
	// Pacing and pairing
	// ============================================================

	assign tick    = div_cnt == '0;
	assign fifo_rd = tick && msu_audio_playing && !fifo_empty;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			div_cnt  <= DIV_W'(`MSU_SAMPLE_DIV);
			rd_valid <= 1'b0;
			is_left  <= 1'b1;
			pair_l   <= '0;
			pair_r   <= '0;
		end else begin
			div_cnt  <= tick ? DIV_W'(`MSU_SAMPLE_DIV) : div_cnt - 1'b1;
			// FIFO data is valid the cycle after the read
			rd_valid <= fifo_rd;
			if (first_sample_sync) begin
				is_left <= 1'b1;
			end else if (rd_valid) begin
				is_left <= !is_left;
			end
			// Both channels change together on the right word
			if (rd_valid && !is_left) begin
				pair_l <= held_left;
				pair_r <= fifo_dout;
			end
		end
	end

	// Left word waits here for its right partner
	always_ff @(posedge clk_sys) begin
		if (rd_valid && is_left) begin
			held_left <= fifo_dout;
		end
	end

	// ============================================================
	// Mix
	// ============================================================

	// Silence when stopped, stale pair would give a DC offset
	assign msu_l = msu_audio_playing ? pair_l : '0;
	assign msu_r = msu_audio_playing ? pair_r : '0;

	assign mix_l = $signed({main_audio_l[15], main_audio_l}) + $signed({msu_l[15], msu_l});
	assign mix_r = $signed({main_audio_r[15], main_audio_r}) + $signed({msu_r[15], msu_r});

	assign audio_l = pcm_sample_t'(mix_l[16:1]);
	assign audio_r = pcm_sample_t'(mix_r[16:1]);

endmodule

/* hw/msu_audio_pkg.sv */
// ============================================================
// Types for the MSU audio side
// FIFO level is one bit wider than the pointer so a full
// FIFO can be told apart from an empty one
// ============================================================
`include "msu_params.svh"

package msu_audio_pkg;

	// Signed PCM sample, as stored in the track file
	typedef logic signed [15:0] pcm_sample_t;

	// FIFO fill count, 0 up to MSU_FIFO_DEPTH
	typedef logic [$clog2(`MSU_FIFO_DEPTH):0] fifo_level_t;

	// Audio track fetch
	typedef enum logic [1:0] {
		af_idle,
		af_wait_ack,
		af_stream
	} audio_fetch_state_t;

	// Data track fetch
	typedef enum logic [1:0] {
		df_idle,
		df_wait_ack,
		df_fill
	} data_fetch_state_t;

endpackage

/* hw/msu_data_buffer.sv */
// ============================================================
// One-sector cache for the MSU data track
// Byte read is combinational, valid while busy is low
// Little-endian: even address gives the low byte
// ============================================================
`timescale 1ns/1ps
`include "msu_params.svh"

module msu_data_buffer
	import msu_sd_pkg::*;
(
	input  logic         clk_sys,
	input  logic         buf_wr,
	input  sd_word_idx_t buf_idx,
	input  sd_word_t     sd_buff_dout,
	input  logic [31:0]  msu_data_addr,
	output logic [7:0]   msu_data_in
);

	localparam int IDX_HI = $clog2(`MSU_SECTOR_WORDS);

	sd_word_t     mem [`MSU_SECTOR_WORDS];
	sd_word_idx_t rd_idx;
	sd_word_t     rd_word;

	// Host stream fills the sector in word order
	always_ff @(posedge clk_sys) begin
		if (buf_wr) begin
			mem[buf_idx] <= sd_buff_dout;
		end
	end

	// Word within the sector, then byte within the word
	assign rd_idx      = msu_data_addr[IDX_HI:1];
	assign rd_word     = mem[rd_idx];
	assign msu_data_in = msu_data_addr[0] ? rd_word[15:8] : rd_word[7:0];

endmodule

/* hw/msu_params.svh */
// ============================================================
// Build constants for the MSU-1 streaming path
// Sector size and FIFO depth must stay powers of two
// MSU_SAMPLE_DIV sets the pacer rate from clk_sys
// ============================================================
`ifndef MSU_PARAMS_SVH
`define MSU_PARAMS_SVH

// 16-bit words per host sector (512 bytes)
`define MSU_SECTOR_WORDS 256

// PCM FIFO entries
`define MSU_FIFO_DEPTH 2048

// No new audio sector is requested at or above this fill level
`define MSU_FIFO_HIGH_WATER 1792

// "MSU1" tag plus loop index at the start of frame 0
`define MSU_HEADER_WORDS 4

// Pacer reload, one tick every MSU_SAMPLE_DIV+1 cycles
`define MSU_SAMPLE_DIV 566

// Last sector index of a track (1 GB at 512 bytes per sector)
`define MSU_LAST_FRAME 2097151

`endif

/* hw/msu_sample_fifo.sv */
// ============================================================
// Single-clock PCM word FIFO
// Read data appears one cycle after fifo_rd
// fifo_clear empties it synchronously, contents not wiped
// ============================================================
`timescale 1ns/1ps
`include "msu_params.svh"

module msu_sample_fifo
	import msu_sd_pkg::*, msu_audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        fifo_clear,
	input  logic        fifo_wr,
	input  logic        fifo_rd,
	input  sd_word_t    sd_buff_dout,
	output pcm_sample_t fifo_dout,
	output fifo_level_t fifo_level,
	output logic        fifo_empty,
	output logic        fifo_full
);

	localparam int PTR_W = $clog2(`MSU_FIFO_DEPTH);

	sd_word_t         mem [`MSU_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             wr_en;
	logic             rd_en;

	assign fifo_empty = fifo_level == '0;
	assign fifo_full  = fifo_level == fifo_level_t'(`MSU_FIFO_DEPTH);

	// Local guards keep the pointers sane even on a bad request
	assign wr_en = fifo_wr && !fifo_full;
	assign rd_en = fifo_rd && !fifo_empty;

	// Pointers and count
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fifo_level <= '0;
		end else if (fifo_clear) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fifo_level <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr_en && !rd_en) begin
				fifo_level <= fifo_level + 1'b1;
			end else if (rd_en && !wr_en) begin
				fifo_level <= fifo_level - 1'b1;
			end
		end
	end

	// Storage and registered read port
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_ptr] <= sd_buff_dout;
		end
		if (rd_en) begin
			fifo_dout <= pcm_sample_t'(mem[rd_ptr]);
		end
	end

	// Mixer must only read when data is there
	a_no_empty_read: assert property (@(posedge clk_sys) disable iff (reset)
		fifo_rd |-> !fifo_empty);

	// Controller must hold words back when full
	a_no_full_write: assert property (@(posedge clk_sys) disable iff (reset)
		fifo_wr |-> !fifo_full);

endmodule

/* hw/msu_sd_pkg.sv */
// ============================================================
// Types for the host sector side
// Word index width follows MSU_SECTOR_WORDS
// ============================================================
`include "msu_params.svh"

package msu_sd_pkg;

	// Host block address, one 512-byte sector per step
	typedef logic [31:0] sd_lba_t;

	// One word of the host sector stream
	typedef logic [15:0] sd_word_t;

	// Word position inside one sector
	typedef logic [$clog2(`MSU_SECTOR_WORDS)-1:0] sd_word_idx_t;

	// Byte address bits below the sector number
	localparam int SECTOR_SHIFT = $clog2(`MSU_SECTOR_WORDS) + 1;

endpackage

/* hw/msu_sector_ctrl.sv */
// ============================================================
// Sector fetch control for the MSU audio and data tracks
// Host handshake is level based: request, ack, word strobes
// Only one request level is ever high at a time
// Playback stops after MSU_LAST_FRAME, no repeat mode
// ============================================================
`timescale 1ns/1ps
`include "msu_params.svh"

module msu_sector_ctrl
	import msu_sd_pkg::*, msu_audio_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         msu_trig_play,
	input  logic         msu_trackmounting,
	input  logic [31:0]  msu_data_addr,
	input  logic         sd_ack_audio,
	input  logic         sd_ack_data,
	input  logic         sd_buff_wr,
	input  fifo_level_t  fifo_level,
	input  logic         fifo_full,
	output logic         sd_rd_audio,
	output logic         sd_rd_data,
	output sd_lba_t      sd_lba_audio,
	output sd_lba_t      sd_lba_data,
	output logic         fifo_wr,
	output logic         fifo_clear,
	output logic         first_sample_sync,
	output logic         msu_audio_playing,
	output logic         msu_data_busy,
	output logic         buf_wr,
	output sd_word_idx_t buf_idx
);

	localparam int FRAME_W  = $clog2(`MSU_LAST_FRAME + 1);
	localparam int SECTOR_W = 32 - SECTOR_SHIFT;

	audio_fetch_state_t    af_state;
	data_fetch_state_t     df_state;
	logic [FRAME_W-1:0]    cur_frame;
	sd_word_idx_t          word_cnt;
	sd_word_idx_t          data_idx;
	// Extra top bit makes the reset value unreachable from any address
	logic [SECTOR_W:0]     cached_sector;
	logic                  sector_miss;
	logic                  data_req_go;
	logic                  audio_slot;
	logic                  audio_word;
	logic                  header_skip;

	// ============================================================
	// Channel arbitration
	// ============================================================

	assign sector_miss = cached_sector != {1'b0, msu_data_addr[31:SECTOR_SHIFT]};

	// Data request may start only while no audio request is pending
	assign data_req_go = (df_state == df_idle) && sector_miss && !sd_rd_audio;

	// Audio request yields to a starting or pending data request
	assign audio_slot = !data_req_go && !sd_rd_data;

	// ============================================================
	// Audio stream filtering
	// ============================================================

	// Words of an aborted sector arrive while idle and are dropped
	assign audio_word = sd_ack_audio && sd_buff_wr && (af_state != af_idle);

	// Frame 0 starts with the tag and loop words
	assign header_skip = (sd_lba_audio == '0) && (word_cnt < `MSU_HEADER_WORDS);

	assign fifo_wr = audio_word && msu_audio_playing && !header_skip && !fifo_full;

	// First word after the header is the left sample of the first pair
	assign first_sample_sync = fifo_wr && (sd_lba_audio == '0)
		&& (word_cnt == `MSU_HEADER_WORDS);

	// Trigger flushes anything left over from the previous track
	assign fifo_clear = msu_trig_play;

	// Audio fetch FSM
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			af_state          <= af_idle;
			msu_audio_playing <= 1'b0;
			cur_frame         <= '0;
			word_cnt          <= '0;
			sd_rd_audio       <= 1'b0;
			sd_lba_audio      <= '0;
		end else begin
			if (audio_word) begin
				word_cnt <= word_cnt + 1'b1;
			end
			case (af_state)
				af_idle: begin
					// Wait for the host to finish any sector it still holds
					if (msu_audio_playing && !msu_trackmounting && !sd_ack_audio
						&& audio_slot) begin
						sd_lba_audio <= sd_lba_t'(cur_frame);
						sd_rd_audio  <= 1'b1;
						word_cnt     <= '0;
						af_state     <= af_wait_ack;
					end
				end
				af_wait_ack: begin
					if (sd_ack_audio) begin
						sd_rd_audio <= 1'b0;
						af_state    <= af_stream;
					end
				end
				af_stream: begin
					// Ack low means the sector is done, FIFO level gives back-pressure
					if (!sd_ack_audio && fifo_level < `MSU_FIFO_HIGH_WATER) begin
						if (msu_audio_playing && cur_frame < FRAME_W'(`MSU_LAST_FRAME)) begin
							if (audio_slot) begin
								cur_frame    <= cur_frame + 1'b1;
								sd_lba_audio <= sd_lba_t'(cur_frame + 1'b1);
								sd_rd_audio  <= 1'b1;
								word_cnt     <= '0;
								af_state     <= af_wait_ack;
							end
						end else begin
							// End of track
							msu_audio_playing <= 1'b0;
							af_state          <= af_idle;
						end
					end
				end
				default: af_state <= af_idle;
			endcase
			// Trigger restarts from frame 0 whatever the FSM was doing
			if (msu_trig_play) begin
				msu_audio_playing <= 1'b1;
				cur_frame         <= '0;
				sd_rd_audio       <= 1'b0;
				af_state          <= af_idle;
			end
		end
	end

	// ============================================================
	// Data track sector cache fill
	// ============================================================

	assign buf_wr  = sd_ack_data && sd_buff_wr && (df_state != df_idle);
	assign buf_idx = data_idx;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			df_state      <= df_idle;
			sd_rd_data    <= 1'b0;
			sd_lba_data   <= '0;
			msu_data_busy <= 1'b0;
			data_idx      <= '0;
			cached_sector <= {1'b1, {SECTOR_W{1'b0}}};
		end else begin
			if (buf_wr) begin
				data_idx <= data_idx + 1'b1;
			end
			case (df_state)
				df_idle: begin
					if (data_req_go) begin
						cached_sector <= {1'b0, msu_data_addr[31:SECTOR_SHIFT]};
						sd_lba_data   <= sd_lba_t'(msu_data_addr >> SECTOR_SHIFT);
						sd_rd_data    <= 1'b1;
						msu_data_busy <= 1'b1;
						data_idx      <= '0;
						df_state      <= df_wait_ack;
					end
				end
				df_wait_ack: begin
					if (sd_ack_data) begin
						sd_rd_data <= 1'b0;
						df_state   <= df_fill;
					end
				end
				df_fill: begin
					// Buffer is complete once the host drops the ack
					if (!sd_ack_data) begin
						msu_data_busy <= 1'b0;
						df_state      <= df_idle;
					end
				end
				default: df_state <= df_idle;
			endcase
		end
	end

	// Host serves one channel at a time
	a_one_request: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd_audio && sd_rd_data));

endmodule

/* hw/msu_top.sv */
// ============================================================
// MSU-1 streaming path top level
// Single clock domain, async active-high reset
// Host side expects one sector server for both channels
// ============================================================
`timescale 1ns/1ps

module msu_top
	import msu_sd_pkg::*, msu_audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	// Host sector server
	output logic        sd_rd_audio,
	output sd_lba_t     sd_lba_audio,
	output logic        sd_rd_data,
	output sd_lba_t     sd_lba_data,
	input  logic        sd_ack_audio,
	input  logic        sd_ack_data,
	input  sd_word_t    sd_buff_dout,
	input  logic        sd_buff_wr,
	// MSU core
	input  logic        msu_trig_play,
	input  logic        msu_trackmounting,
	input  logic [31:0] msu_data_addr,
	output logic [7:0]  msu_data_in,
	output logic        msu_data_busy,
	output logic        msu_audio_playing,
	// Audio
	input  pcm_sample_t main_audio_l,
	input  pcm_sample_t main_audio_r,
	output pcm_sample_t audio_l,
	output pcm_sample_t audio_r
);

	logic         fifo_wr;
	logic         fifo_rd;
	logic         fifo_clear;
	logic         fifo_empty;
	logic         fifo_full;
	fifo_level_t  fifo_level;
	pcm_sample_t  fifo_dout;
	logic         first_sample_sync;
	logic         buf_wr;
	sd_word_idx_t buf_idx;

	msu_sector_ctrl ctrl_i (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.msu_trig_play     (msu_trig_play),
		.msu_trackmounting (msu_trackmounting),
		.msu_data_addr     (msu_data_addr),
		.sd_ack_audio      (sd_ack_audio),
		.sd_ack_data       (sd_ack_data),
		.sd_buff_wr        (sd_buff_wr),
		.fifo_level        (fifo_level),
		.fifo_full         (fifo_full),
		.sd_rd_audio       (sd_rd_audio),
		.sd_rd_data        (sd_rd_data),
		.sd_lba_audio      (sd_lba_audio),
		.sd_lba_data       (sd_lba_data),
		.fifo_wr           (fifo_wr),
		.fifo_clear        (fifo_clear),
		.first_sample_sync (first_sample_sync),
		.msu_audio_playing (msu_audio_playing),
		.msu_data_busy     (msu_data_busy),
		.buf_wr            (buf_wr),
		.buf_idx           (buf_idx)
	);

	msu_sample_fifo fifo_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.fifo_clear   (fifo_clear),
		.fifo_wr      (fifo_wr),
		.fifo_rd      (fifo_rd),
		.sd_buff_dout (sd_buff_dout),
		.fifo_dout    (fifo_dout),
		.fifo_level   (fifo_level),
		.fifo_empty   (fifo_empty),
		.fifo_full    (fifo_full)
	);

	msu_audio_mixer mixer_i (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.msu_audio_playing (msu_audio_playing),
		.fifo_empty        (fifo_empty),
		.first_sample_sync (first_sample_sync),
		.fifo_dout         (fifo_dout),
		.main_audio_l      (main_audio_l),
		.main_audio_r      (main_audio_r),
		.fifo_rd           (fifo_rd),
		.audio_l           (audio_l),
		.audio_r           (audio_r)
	);

	msu_data_buffer data_buf_i (
		.clk_sys       (clk_sys),
		.buf_wr        (buf_wr),
		.buf_idx       (buf_idx),
		.sd_buff_dout  (sd_buff_dout),
		.msu_data_addr (msu_data_addr),
		.msu_data_in   (msu_data_in)
	);

endmodule
